//--- src/replay_pkg.sv
/*
  Shared types for the stream replayer
  Configuration fields are CFG_W bits, so block size and repeat count top out at 255
*/
package replay_pkg;

  localparam int CFG_W = 8;

  // Programmed block shape
  typedef struct packed {
    logic [CFG_W-1:0] size_n;
    logic [CFG_W-1:0] repeat_n;
  } replay_cfg_t;

  // Sideband carried with every outgoing beat
  typedef struct packed {
    logic [CFG_W-1:0] rep;
    logic             first;
    logic             last;
  } replay_tag_t;

  typedef enum logic {
    CFG_IDLE,
    CFG_ACTIVE
  } cfg_state_e;

endpackage

//--- src/simple_dual_port_ram.sv
/*
  Single-clock RAM with one write port and one read port
  Read data is registered and appears one cycle after rd_addr
  A read of the address being written returns the old word; contents are not reset
*/
`timescale 1ns/1ns

module simple_dual_port_ram #(
  parameter int DATA_WIDTH = 16,
  parameter int ADDR_WIDTH = 3
) (
  input  logic                  clk,
  input  logic                  wr_en,
  input  logic [ADDR_WIDTH-1:0] wr_addr,
  input  logic [DATA_WIDTH-1:0] wr_data,
  input  logic [ADDR_WIDTH-1:0] rd_addr,
  output logic [DATA_WIDTH-1:0] rd_data
);

  logic [DATA_WIDTH-1:0] mem [2**ADDR_WIDTH];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
    rd_data <= mem[rd_addr];
  end

endmodule

//--- src/replay_config.sv
/*
  Holds the active block size and repeat count, 1/1 after reset
  A new setting is taken only while the replayer is idle and is clamped to
  1..MAX_SIZE and 1..MAX_REPEAT. A beat accepted on the same cycle as a new
  setting is the first beat of a block under the new setting
*/
`timescale 1ns/1ns

module replay_config #(
  parameter int MAX_SIZE   = 8,
  parameter int MAX_REPEAT = 4
) (
  input  logic                    clk,
  input  logic                    rst,
  input  replay_pkg::replay_cfg_t cfg,
  input  logic                    cfg_valid,
  input  logic                    idle,
  input  logic                    in_accept,
  output logic                    cfg_ready,
  output replay_pkg::replay_cfg_t active_cfg
);

  localparam logic [replay_pkg::CFG_W-1:0] SIZE_LIMIT = MAX_SIZE[replay_pkg::CFG_W-1:0];
  localparam logic [replay_pkg::CFG_W-1:0] REPEAT_LIMIT = MAX_REPEAT[replay_pkg::CFG_W-1:0];

  replay_pkg::cfg_state_e state;

  // Zero means one, anything past the limit means the limit
  function automatic logic [replay_pkg::CFG_W-1:0] clamp(
    input logic [replay_pkg::CFG_W-1:0] value,
    input logic [replay_pkg::CFG_W-1:0] limit
  );
    logic [replay_pkg::CFG_W-1:0] result;
    result = value;
    if (value == '0) begin
      result = 'd1;
    end else if (value > limit) begin
      result = limit;
    end
    return result;
  endfunction

  assign cfg_ready = (state == replay_pkg::CFG_IDLE) && idle;

  always_ff @(posedge clk) begin
    if (rst) begin
      state               <= replay_pkg::CFG_IDLE;
      active_cfg.size_n   <= 'd1;
      active_cfg.repeat_n <= 'd1;
    end else begin
      case (state)
        replay_pkg::CFG_IDLE: begin
          if (in_accept) begin
            state <= replay_pkg::CFG_ACTIVE;
          end
        end
        replay_pkg::CFG_ACTIVE: begin
          // Back to idle once the last block has fully drained
          if (idle && !in_accept) begin
            state <= replay_pkg::CFG_IDLE;
          end
        end
        default: state <= replay_pkg::CFG_IDLE;
      endcase
      if (cfg_valid && cfg_ready) begin
        active_cfg.size_n   <= clamp(cfg.size_n, SIZE_LIMIT);
        active_cfg.repeat_n <= clamp(cfg.repeat_n, REPEAT_LIMIT);
      end
    end
  end

endmodule

//--- src/replay_out_stage.sv
/*
  Two-register output buffer behind the RAM
  rd_issue must arrive on the same cycle as the RAM read data it qualifies
  Holds up to two beats while out_ready is low; beats leave in arrival order
*/
`timescale 1ns/1ns

module replay_out_stage #(
  parameter int DATA_WIDTH = 16
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    rd_issue,
  input  replay_pkg::replay_tag_t rd_tag,
  input  logic [DATA_WIDTH-1:0]   ram_rd_data,
  input  logic                    out_ready,
  output logic [DATA_WIDTH-1:0]   out_data,
  output replay_pkg::replay_tag_t out_tag,
  output logic                    out_valid,
  output logic                    stage_hold,
  output logic                    stage_empty
);

  typedef struct packed {
    replay_pkg::replay_tag_t tag;
    logic [DATA_WIDTH-1:0]   data;
  } beat_t;

  beat_t main_q;
  beat_t extra_q;
  beat_t incoming;
  logic  main_valid;
  logic  extra_valid;
  // Set while the extra register holds the oldest beat
  logic  sel_extra;
  logic  pop_main;
  logic  pop_extra;
  logic  to_main;
  logic  to_extra;

  assign incoming.tag  = rd_tag;
  assign incoming.data = ram_rd_data;

  assign pop_main  = out_ready && !sel_extra && main_valid;
  assign pop_extra = out_ready && sel_extra && extra_valid;

  // A returning read parks in the extra register only while main is stuck
  assign to_extra = rd_issue && main_valid && !out_ready;
  assign to_main  = rd_issue && !to_extra;

  assign out_valid = sel_extra ? extra_valid : main_valid;
  assign out_data  = sel_extra ? extra_q.data : main_q.data;
  assign out_tag   = sel_extra ? extra_q.tag : main_q.tag;

  // One read may already be in flight, so stop issuing as soon as anything is held
  assign stage_hold  = !out_ready && (main_valid || extra_valid);
  assign stage_empty = !main_valid && !extra_valid && !rd_issue;

  always_ff @(posedge clk) begin
    if (rst) begin
      main_valid  <= 1'b0;
      extra_valid <= 1'b0;
      sel_extra   <= 1'b0;
    end else begin
      if (to_main) begin
        main_valid <= 1'b1;
      end else if (pop_main) begin
        main_valid <= 1'b0;
      end
      if (to_extra) begin
        extra_valid <= 1'b1;
      end else if (pop_extra) begin
        extra_valid <= 1'b0;
      end
      if (pop_main && extra_valid) begin
        sel_extra <= 1'b1;
      end else if (pop_extra) begin
        sel_extra <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (to_main) begin
      main_q <= incoming;
    end
    if (to_extra) begin
      extra_q <= incoming;
    end
  end

endmodule

//--- src/repeat_circular_buffer.sv
/*
  Pointer, repetition and occupancy control around the replay RAM
  The RAM is used as a ring of active_cfg.size_n slots; ADDR_WIDTH must not exceed CFG_W
  The next block is written into slots freed during the final repetition
  in_ready stays low on the first cycle after reset
*/
`timescale 1ns/1ns

module repeat_circular_buffer #(
  parameter int ADDR_WIDTH = 3
) (
  input  logic                    clk,
  input  logic                    rst,
  input  replay_pkg::replay_cfg_t active_cfg,
  input  logic                    in_valid,
  input  logic                    stage_hold,
  input  logic                    stage_empty,
  output logic                    in_ready,
  output logic                    in_accept,
  output logic                    ram_wr_en,
  output logic [ADDR_WIDTH-1:0]   ram_wr_addr,
  output logic [ADDR_WIDTH-1:0]   ram_rd_addr,
  output logic                    rd_issue,
  output replay_pkg::replay_tag_t rd_tag,
  output logic                    idle
);

  logic [replay_pkg::CFG_W-1:0] wr_ptr;
  logic [replay_pkg::CFG_W-1:0] rd_ptr;
  logic [replay_pkg::CFG_W-1:0] rep;
  // Beats stored and not yet freed by their final repetition
  logic [replay_pkg::CFG_W-1:0] count;
  logic                         started;
  logic                         last_rep;
  logic                         wr_done;
  logic                         rd_at_end;
  logic                         block_full;
  logic                         overwrite;
  logic                         rd_written;
  logic                         rd_go;
  logic                         rd_free;
  replay_pkg::replay_tag_t      issue_tag;

  assign last_rep  = rep == active_cfg.repeat_n - 'd1;
  assign wr_done   = wr_ptr == active_cfg.size_n;
  assign rd_at_end = rd_ptr == active_cfg.size_n - 'd1;

  // Input side
  assign block_full = count == active_cfg.size_n;
  // Writer caught up with the reader on a slot still owed to the final pass
  assign overwrite  = (active_cfg.repeat_n != 'd1) && last_rep && (wr_ptr == rd_ptr);
  assign in_ready   = started && !wr_done && !block_full && !overwrite;
  assign in_accept  = in_valid && in_ready;

  assign ram_wr_en   = in_accept;
  assign ram_wr_addr = wr_ptr[ADDR_WIDTH-1:0];
  assign ram_rd_addr = rd_ptr[ADDR_WIDTH-1:0];

  // Before the final pass the reader may not run ahead of the writer
  assign rd_written = last_rep || (count > rd_ptr);
  assign rd_go      = (count != '0) && !stage_hold && rd_written;
  assign rd_free    = rd_go && last_rep;

  always_comb begin
    issue_tag.rep   = rep;
    issue_tag.first = rd_ptr == '0;
    issue_tag.last  = last_rep && rd_at_end;
  end

  assign idle = (count == '0) && (wr_ptr == '0) && stage_empty;

  always_ff @(posedge clk) begin
    if (rst) begin
      started  <= 1'b0;
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      rep      <= '0;
      count    <= '0;
      rd_issue <= 1'b0;
    end else begin
      started <= 1'b1;

      // Writer parks at the block end until the final repetition starts
      if (in_accept) begin
        wr_ptr <= wr_ptr + 'd1;
      end else if (wr_done && last_rep) begin
        wr_ptr <= '0;
      end

      if (rd_go) begin
        if (rd_at_end) begin
          rd_ptr <= '0;
          rep    <= last_rep ? '0 : rep + 'd1;
        end else begin
          rd_ptr <= rd_ptr + 'd1;
        end
      end

      if (in_accept && !rd_free) begin
        count <= count + 'd1;
      end else if (!in_accept && rd_free) begin
        count <= count - 'd1;
      end

      rd_issue <= rd_go;
    end
  end

  // Tag travels with the read, aligned to the RAM output
  always_ff @(posedge clk) begin
    if (rd_go) begin
      rd_tag <= issue_tag;
    end
  end

endmodule

//--- src/stream_replayer.sv
/*
  Stream replayer top: stores blocks of size_n beats and sends each repeat_n times
  Configuration is taken only while idle; defaults to size 1, repeat 1
  MAX_SIZE and MAX_REPEAT must not exceed 255
*/
`timescale 1ns/1ns

module stream_replayer #(
  parameter int DATA_WIDTH = 16,
  parameter int MAX_SIZE   = 8,
  parameter int MAX_REPEAT = 4
) (
  input  logic                    clk,
  input  logic                    rst,
  input  replay_pkg::replay_cfg_t cfg,
  input  logic                    cfg_valid,
  output logic                    cfg_ready,
  input  logic [DATA_WIDTH-1:0]   in_data,
  input  logic                    in_valid,
  output logic                    in_ready,
  output logic [DATA_WIDTH-1:0]   out_data,
  output replay_pkg::replay_tag_t out_tag,
  output logic                    out_valid,
  input  logic                    out_ready
);

  localparam int ADDR_WIDTH = (MAX_SIZE > 1) ? $clog2(MAX_SIZE) : 1;

  replay_pkg::replay_cfg_t active_cfg;
  replay_pkg::replay_tag_t rd_tag;
  logic                    idle;
  logic                    in_accept;
  logic                    ram_wr_en;
  logic [ADDR_WIDTH-1:0]   ram_wr_addr;
  logic [ADDR_WIDTH-1:0]   ram_rd_addr;
  logic [DATA_WIDTH-1:0]   ram_rd_data;
  logic                    rd_issue;
  logic                    stage_hold;
  logic                    stage_empty;

  replay_config #(
    .MAX_SIZE  (MAX_SIZE),
    .MAX_REPEAT(MAX_REPEAT)
  ) u_config (
    .clk       (clk),
    .rst       (rst),
    .cfg       (cfg),
    .cfg_valid (cfg_valid),
    .idle      (idle),
    .in_accept (in_accept),
    .cfg_ready (cfg_ready),
    .active_cfg(active_cfg)
  );

  repeat_circular_buffer #(
    .ADDR_WIDTH(ADDR_WIDTH)
  ) u_buffer (
    .clk        (clk),
    .rst        (rst),
    .active_cfg (active_cfg),
    .in_valid   (in_valid),
    .stage_hold (stage_hold),
    .stage_empty(stage_empty),
    .in_ready   (in_ready),
    .in_accept  (in_accept),
    .ram_wr_en  (ram_wr_en),
    .ram_wr_addr(ram_wr_addr),
    .ram_rd_addr(ram_rd_addr),
    .rd_issue   (rd_issue),
    .rd_tag     (rd_tag),
    .idle       (idle)
  );

  simple_dual_port_ram #(
    .DATA_WIDTH(DATA_WIDTH),
    .ADDR_WIDTH(ADDR_WIDTH)
  ) u_ram (
    .clk    (clk),
    .wr_en  (ram_wr_en),
    .wr_addr(ram_wr_addr),
    .wr_data(in_data),
    .rd_addr(ram_rd_addr),
    .rd_data(ram_rd_data)
  );

  replay_out_stage #(
    .DATA_WIDTH(DATA_WIDTH)
  ) u_out (
    .clk        (clk),
    .rst        (rst),
    .rd_issue   (rd_issue),
    .rd_tag     (rd_tag),
    .ram_rd_data(ram_rd_data),
    .out_ready  (out_ready),
    .out_data   (out_data),
    .out_tag    (out_tag),
    .out_valid  (out_valid),
    .stage_hold (stage_hold),
    .stage_empty(stage_empty)
  );

endmodule

//--- tb/stream_replayer_tb.sv
/*
  Testbench for the stream replayer with a queue-based reference model
  Runs the default parameters: 16-bit data, MAX_SIZE 8, MAX_REPEAT 4
  Outputs are sampled on the falling edge, inputs change on the rising edge
*/
`timescale 1ns/1ns

module stream_replayer_tb;

  localparam int DATA_WIDTH  = 16;
  localparam int MAX_SIZE    = 8;
  localparam int MAX_REPEAT  = 4;
  localparam int CW          = replay_pkg::CFG_W;
  localparam int BEAT_LIMIT  = 500;
  localparam int DRAIN_LIMIT = 2000;

  logic                    clk;
  logic                    rst;
  replay_pkg::replay_cfg_t cfg;
  logic                    cfg_valid;
  logic                    cfg_ready;
  logic [DATA_WIDTH-1:0]   in_data;
  logic                    in_valid;
  logic                    in_ready;
  logic [DATA_WIDTH-1:0]   out_data;
  replay_pkg::replay_tag_t out_tag;
  logic                    out_valid;
  logic                    out_ready;

  // Reference model state for the block being filled and the expected output
  logic [DATA_WIDTH-1:0]   blk [$];
  logic [DATA_WIDTH-1:0]   exp_data [$];
  replay_pkg::replay_tag_t exp_tag [$];
  int                      model_size = 1;
  int                      model_repeat = 1;
  int                      stall_pct = 0;
  int                      mismatches = 0;
  int                      timeouts = 0;
  int                      other_errors = 0;
  logic                    in_reset = 1'b0;
  logic                    held = 1'b0;
  logic [DATA_WIDTH-1:0]   held_data;
  replay_pkg::replay_tag_t held_tag;

  stream_replayer #(
    .DATA_WIDTH(DATA_WIDTH),
    .MAX_SIZE  (MAX_SIZE),
    .MAX_REPEAT(MAX_REPEAT)
  ) dut (
    .clk      (clk),
    .rst      (rst),
    .cfg      (cfg),
    .cfg_valid(cfg_valid),
    .cfg_ready(cfg_ready),
    .in_data  (in_data),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .out_data (out_data),
    .out_tag  (out_tag),
    .out_valid(out_valid),
    .out_ready(out_ready)
  );

  // Zero becomes one, values past the limit become the limit
  function automatic int saturate(input int value, input int limit);
    if (value == 0) begin
      return 1;
    end
    return (value > limit) ? limit : value;
  endfunction

  // Expected beat at block position pos of repetition r
  task automatic expect_beat(input logic [DATA_WIDTH-1:0] data, input int r, input int pos);
    replay_pkg::replay_tag_t tag;
    tag.rep   = CW'(r);
    tag.first = (pos == 0);
    tag.last  = (r == model_repeat - 1) && (pos == model_size - 1);
    exp_data.push_back(data);
    exp_tag.push_back(tag);
  endtask

  // Later repetitions can only start once the whole block is in
  task automatic queue_repeats();
    for (int r = 1; r < model_repeat; r++) begin
      for (int p = 0; p < model_size; p++) begin
        expect_beat(blk[p], r, p);
      end
    end
    blk.delete();
  endtask

  task automatic drive_cfg(input int size, input int repeats);
    @(posedge clk);
    cfg.size_n   <= CW'(size);
    cfg.repeat_n <= CW'(repeats);
    cfg_valid    <= 1'b1;
    @(posedge clk);
    cfg_valid <= 1'b0;
  endtask

  task automatic apply_cfg(input int size, input int repeats);
    int waited;
    waited = 0;
    @(negedge clk);
    while (!cfg_ready && waited < DRAIN_LIMIT) begin
      waited++;
      @(negedge clk);
    end
    assert (cfg_ready) else begin
      timeouts++;
      $display("timeout waiting for cfg_ready before a new configuration");
    end
    drive_cfg(size, repeats);
  endtask

  task automatic send_beats(input int n, input int max_gap);
    int gap;
    int waited;
    for (int i = 0; i < n; i++) begin
      gap = $urandom_range(max_gap, 0);
      @(posedge clk);
      in_valid <= 1'b0;
      repeat (gap) @(posedge clk);
      in_valid <= 1'b1;
      in_data  <= DATA_WIDTH'($urandom);
      waited = 0;
      @(negedge clk);
      while (!in_ready && waited < BEAT_LIMIT) begin
        waited++;
        @(negedge clk);
      end
      assert (in_ready) else begin
        timeouts++;
        $display("timeout waiting for in_ready on input beat %0d", i);
      end
    end
    @(posedge clk);
    in_valid <= 1'b0;
  endtask

  // Idle again with every expected beat delivered
  task automatic wait_drain();
    int waited;
    waited = 0;
    @(negedge clk);
    while (!(cfg_ready && exp_data.size() == 0) && waited < DRAIN_LIMIT) begin
      waited++;
      @(negedge clk);
    end
    assert (cfg_ready && exp_data.size() == 0) else begin
      timeouts++;
      $display("timeout waiting for the replayer to drain, %0d beats missing", exp_data.size());
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  initial begin
    out_ready = 1'b1;
    forever begin
      @(posedge clk);
      out_ready <= (stall_pct == 0) || ($urandom_range(99, 0) >= stall_pct);
    end
  end

  always @(negedge clk) begin
    if (rst) begin
      in_reset = 1'b1;
    end else begin
      if (in_reset) begin
        assert (out_valid == 1'b0) else begin
          mismatches++;
          $display("mismatch out_valid after reset: got 0x%h expected 0x0", out_valid);
        end
        assert (in_ready == 1'b0) else begin
          mismatches++;
          $display("mismatch in_ready after reset: got 0x%h expected 0x0", in_ready);
        end
        assert (cfg_ready == 1'b1) else begin
          mismatches++;
          $display("mismatch cfg_ready after reset: got 0x%h expected 0x1", cfg_ready);
        end
        in_reset = 1'b0;
      end
      if (cfg_valid && cfg_ready) begin
        assert (blk.size() == 0) else begin
          other_errors++;
          $display("configuration accepted while a block was part-written");
        end
        model_size   = saturate(int'(cfg.size_n), MAX_SIZE);
        model_repeat = saturate(int'(cfg.repeat_n), MAX_REPEAT);
      end
      if (in_valid && in_ready) begin
        expect_beat(in_data, 0, blk.size());
        blk.push_back(in_data);
        if (blk.size() == model_size) begin
          queue_repeats();
        end
      end
      // A stalled beat must stay put until taken
      if (held) begin
        assert (out_valid == 1'b1) else begin
          mismatches++;
          $display("mismatch out_valid while stalled: got 0x%h expected 0x1", out_valid);
        end
        assert (out_data == held_data) else begin
          mismatches++;
          $display("mismatch out_data while stalled: got 0x%h expected 0x%h", out_data, held_data);
        end
        assert (out_tag == held_tag) else begin
          mismatches++;
          $display("mismatch out_tag while stalled: got 0x%h expected 0x%h", out_tag, held_tag);
        end
      end
      if (out_valid && out_ready) begin
        assert (exp_data.size() != 0) else begin
          other_errors++;
          $display("output beat 0x%h arrived with no beat expected", out_data);
        end
        if (exp_data.size() != 0) begin
          assert (out_data == exp_data[0]) else begin
            mismatches++;
            $display("mismatch out_data: got 0x%h expected 0x%h", out_data, exp_data[0]);
          end
          assert (out_tag == exp_tag[0]) else begin
            mismatches++;
            $display("mismatch out_tag: got 0x%h expected 0x%h", out_tag, exp_tag[0]);
          end
          void'(exp_data.pop_front());
          void'(exp_tag.pop_front());
        end
      end
      held      = out_valid && !out_ready;
      held_data = out_data;
      held_tag  = out_tag;
    end
  end

  initial begin
    void'($urandom(58));
    rst       = 1'b1;
    cfg       = '0;
    cfg_valid = 1'b0;
    in_valid  = 1'b0;
    in_data   = '0;
    repeat (16) @(posedge clk);
    rst <= 1'b0;

    // Default size 1, repeat 1
    send_beats(6, 2);
    wait_drain();
    apply_cfg(5, 3);
    send_beats(10, 0);
    wait_drain();
    stall_pct = 35;
    send_beats(15, 1);
    wait_drain();

    // Out-of-range settings get clamped
    apply_cfg(0, 0);
    send_beats(3, 1);
    wait_drain();
    apply_cfg(200, 9);
    send_beats(16, 1);
    wait_drain();

    // Pulse in the middle of a block must be ignored
    stall_pct = 0;
    apply_cfg(4, 2);
    send_beats(2, 0);
    drive_cfg(3, 3);
    send_beats(2, 1);
    wait_drain();
    apply_cfg(3, 3);
    send_beats(6, 0);
    wait_drain();

    // Back-to-back blocks with refill overlapping the final pass
    stall_pct = 30;
    apply_cfg(7, 3);
    send_beats(35, 3);
    wait_drain();

    $display("errors: %0d mismatches, %0d timeouts, %0d other",
             mismatches, timeouts, other_errors);
    if (mismatches + timeouts + other_errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

//--- stream_replayer.f
src/replay_pkg.sv
src/simple_dual_port_ram.sv
src/replay_config.sv
src/replay_out_stage.sv
src/repeat_circular_buffer.sv
src/stream_replayer.sv
tb/stream_replayer_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compile and run the stream replayer testbench with Verilator
set -o pipefail
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f stream_replayer.f \
  --top-module stream_replayer_tb --Mdir obj_dir \
  && ./obj_dir/Vstream_replayer_tb 2>&1 | tee sim.log \
  || { echo "Build or simulation error"; exit 1; }

grep -qx "TB PASSED" sim.log && echo "Simulation passed" \
  || { echo "Simulation failed, see sim.log"; exit 1; }
